// File: design/unalign_pkg.sv
// ========================================
// unaligned bridge shared types
// ========================================
package unalign_pkg;

  // ========================================
  // bus geometry
  // ========================================
  // one 32-bit word per downstream beat
  localparam int DATA_W = 32;
  // one mask bit per byte
  localparam int STRB_W = DATA_W / 8;
  // byte offset inside a word
  localparam int OFFS_W = $clog2(STRB_W);

  // ========================================
  // beat progress
  // ========================================
  // shared by the issue side and the response side
  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    FIRST = 2'b01,
    BURST = 2'b10
  } beat_state_t;

endpackage

// File: design/icb_cmd_fifo.sv
// ========================================
// ICB outstanding command queue
// ========================================
module icb_cmd_fifo #(
  parameter int ADDR_W     = 32,
  parameter int LEN_W      = 3,
  parameter int OUTS_DEPTH = 16
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push,
  input  logic [ADDR_W-1:0] push_addr,
  input  logic              push_read,
  input  logic [LEN_W-1:0]  push_len,
  input  logic              pop,
  output logic              full,
  output logic              pop_valid,
  output logic [ADDR_W-1:0] pop_addr,
  output logic              pop_read,
  output logic [LEN_W-1:0]  pop_len
);

  // depth rounded up to a power of two
  localparam int DEPTH = 2 ** $clog2(OUTS_DEPTH);
  localparam int PTR_W = $clog2(DEPTH);
  // entry is {read, len, addr}
  localparam int ENT_W = ADDR_W + LEN_W + 1;

  logic [ENT_W-1:0] mem [DEPTH];
  // extra top bit tells full from empty
  logic [PTR_W:0]   wr_ptr;
  logic [PTR_W:0]   rd_ptr;

  assign pop_valid = (wr_ptr != rd_ptr);
  assign full      = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                     (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // storage, no reset
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr[PTR_W-1:0]] <= {push_read, push_len, push_addr};
  end

  // head entry read straight from the array
  assign {pop_read, pop_len, pop_addr} = mem[rd_ptr[PTR_W-1:0]];

  // top gates push with ready, issuer gates pop with valid
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> !full);
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> pop_valid);

endmodule

// File: design/icb_beat_issuer.sv
// ========================================
// ICB downstream beat issuer
// ========================================
module icb_beat_issuer import unalign_pkg::*; #(
  parameter int ADDR_W = 32,
  parameter int LEN_W  = 3
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              fifo_valid,
  input  logic [ADDR_W-1:0] fifo_addr,
  input  logic              fifo_read,
  input  logic [LEN_W-1:0]  fifo_len,
  input  logic              m_cmd_ready,
  input  logic              sa_w_valid,
  input  logic              buf_valid,
  input  logic              rsp_done,
  input  logic              rsp_idle,
  output logic              pop,
  output logic              m_cmd_valid,
  output logic [ADDR_W-1:0] m_cmd_addr,
  output logic              m_cmd_read,
  output logic              sa_w_ready,
  output logic              cur_read,
  output logic [OFFS_W-1:0] cur_offset,
  output logic [LEN_W-1:0]  cur_len,
  output logic              beat_fire,
  output logic              last_beat,
  output beat_state_t       issue_state
);

  logic [ADDR_W-1:0] cur_addr;
  // command popped and its last response not yet seen
  logic              busy;
  logic [LEN_W:0]    beat_cnt;
  logic [LEN_W:0]    last_idx;
  logic              unaligned;
  // final unaligned write beat, data comes from the spill buffer
  logic              buf_beat;

  // ========================================
  // current command
  // ========================================
  assign cur_offset = cur_addr[OFFS_W-1:0];
  assign unaligned  = (cur_offset != '0);
  // len+1 beats, one more when unaligned
  assign last_idx   = {1'b0, cur_len} + (LEN_W+1)'(unaligned);
  assign last_beat  = (beat_cnt == last_idx);
  assign buf_beat   = !cur_read && unaligned && last_beat;

  // one command in flight, next pop on its last response
  assign pop = fifo_valid && (((issue_state == IDLE) && !busy && rsp_idle) || rsp_done);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cur_addr <= '0;
      cur_read <= 1'b0;
      cur_len  <= '0;
      busy     <= 1'b0;
    end else if (pop) begin
      cur_addr <= fifo_addr;
      cur_read <= fifo_read;
      cur_len  <= fifo_len;
      busy     <= 1'b1;
    end else if (rsp_done) begin
      busy <= 1'b0;
    end
  end

  // ========================================
  // issue FSM and beat counter
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_state <= IDLE;
      beat_cnt    <= '0;
    end else if (pop) begin
      issue_state <= FIRST;
      beat_cnt    <= '0;
    end else if (beat_fire) begin
      if (last_beat) begin
        issue_state <= IDLE;
        beat_cnt    <= '0;
      end else begin
        issue_state <= BURST;
        beat_cnt    <= beat_cnt + 1'b1;
      end
    end
  end

  // ========================================
  // downstream command
  // ========================================
  // reads always ready to go, writes wait for data or buffer
  assign m_cmd_valid = (issue_state != IDLE) &&
                       (cur_read || (buf_beat ? buf_valid : sa_w_valid));
  assign beat_fire   = m_cmd_valid && m_cmd_ready;
  // upstream beat taken only together with the downstream beat
  assign sa_w_ready  = (issue_state != IDLE) && !cur_read && !buf_beat && m_cmd_ready;
  // base word plus 4 per beat
  assign m_cmd_addr  = {cur_addr[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}} +
                       (ADDR_W'(beat_cnt) << 2);
  assign m_cmd_read  = cur_read;

  // beats only go out while the popped command is still open
  a_issue_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (issue_state != IDLE) |-> busy);
  // beats of one command walk up one word at a time
  a_addr_step: assert property (@(posedge clk) disable iff (!rst_n)
    (beat_fire && !last_beat && !pop) |=> (m_cmd_addr == $past(m_cmd_addr) + ADDR_W'(4)));

endmodule

// File: design/icb_wdata_realign.sv
// ========================================
// ICB write data realign
// ========================================
module icb_wdata_realign import unalign_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [DATA_W-1:0] sa_wdata,
  input  logic [STRB_W-1:0] sa_wmask,
  input  logic [OFFS_W-1:0] cur_offset,
  input  beat_state_t       issue_state,
  input  logic              beat_fire,
  input  logic              last_beat,
  input  logic              cur_read,
  output logic [DATA_W-1:0] m_wdata,
  output logic [STRB_W-1:0] m_wmask,
  output logic              buf_valid
);

  // low half goes out now, high half spills into the next word
  logic [2*DATA_W-1:0] data_wide;
  logic [2*STRB_W-1:0] mask_wide;
  logic [DATA_W-1:0]   buf_data;
  logic [STRB_W-1:0]   buf_mask;
  logic                unaligned;

  assign unaligned = (cur_offset != '0);
  // byte offset times 8 for the data shift
  assign data_wide = {{DATA_W{1'b0}}, sa_wdata} << {cur_offset, 3'b000};
  assign mask_wide = {{STRB_W{1'b0}}, sa_wmask} << cur_offset;

  // ========================================
  // downstream word build
  // ========================================
  always_comb begin
    m_wdata = '0;
    m_wmask = '0;
    if (!cur_read) begin
      case (issue_state)
        FIRST: begin
          m_wdata = data_wide[DATA_W-1:0];
          m_wmask = mask_wide[STRB_W-1:0];
        end
        BURST: begin
          if (last_beat && unaligned) begin
            // extra beat, spill-over only
            m_wdata = buf_data;
            m_wmask = buf_mask;
          end else begin
            m_wdata = data_wide[DATA_W-1:0] | buf_data;
            m_wmask = mask_wide[STRB_W-1:0] | buf_mask;
          end
        end
        default: ;
      endcase
    end
  end

  // ========================================
  // spill-over buffer
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      buf_valid <= 1'b0;
    end else if (beat_fire && !cur_read) begin
      buf_valid <= !last_beat;
    end
  end

  // aligned commands spill zeros, so the OR above stays clean
  always_ff @(posedge clk) begin
    if (beat_fire && !cur_read && !last_beat) begin
      buf_data <= data_wide[2*DATA_W-1:DATA_W];
      buf_mask <= mask_wide[2*STRB_W-1:STRB_W];
    end
  end

endmodule

// File: design/icb_rsp_realign.sv
// ========================================
// ICB response realign
// ========================================
module icb_rsp_realign import unalign_pkg::*; #(
  parameter int LEN_W = 3
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              m_rsp_valid,
  input  logic [DATA_W-1:0] m_rsp_rdata,
  input  logic              m_rsp_err,
  input  logic              sa_rsp_ready,
  input  logic              cur_read,
  input  logic [OFFS_W-1:0] cur_offset,
  input  logic [LEN_W-1:0]  cur_len,
  output logic              m_rsp_ready,
  output logic              sa_rsp_valid,
  output logic [DATA_W-1:0] sa_rsp_rdata,
  output logic              sa_rsp_err,
  output logic              rsp_done,
  output logic              rsp_idle
);

  beat_state_t         rsp_state;
  logic [LEN_W:0]      rsp_cnt;
  logic [LEN_W:0]      last_idx;
  logic                unaligned;
  logic                rsp_last;
  // this downstream response goes upstream
  logic                fwd;
  logic                rsp_fire;
  // previous downstream word of the same command
  logic [DATA_W-1:0]   rd_buf;
  logic [DATA_W-1:0]   lo_word;
  logic [2*DATA_W-1:0] merge_wide;

  assign unaligned = (cur_offset != '0);
  assign last_idx  = {1'b0, cur_len} + (LEN_W+1)'(unaligned);
  assign rsp_last  = (rsp_cnt == last_idx);

  // ========================================
  // response gating
  // ========================================
  // reads drop the first unaligned word, writes answer once at the end
  assign fwd          = cur_read ? !((rsp_state == IDLE) && unaligned) : rsp_last;
  assign sa_rsp_valid = m_rsp_valid && fwd;
  // absorbed responses never stall
  assign m_rsp_ready  = !fwd || sa_rsp_ready;
  assign rsp_fire     = m_rsp_valid && m_rsp_ready;
  assign rsp_done     = rsp_fire && rsp_last;
  assign rsp_idle     = (rsp_state == IDLE);
  assign sa_rsp_err   = m_rsp_err;

  // ========================================
  // read merge
  // ========================================
  // aligned case shifts by zero and keeps the current word
  assign lo_word      = unaligned ? rd_buf : m_rsp_rdata;
  assign merge_wide   = {m_rsp_rdata, lo_word} >> {cur_offset, 3'b000};
  assign sa_rsp_rdata = cur_read ? merge_wide[DATA_W-1:0] : '0;

  // ========================================
  // response counter
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_state <= IDLE;
      rsp_cnt   <= '0;
    end else if (rsp_fire) begin
      if (rsp_last) begin
        rsp_state <= IDLE;
        rsp_cnt   <= '0;
      end else begin
        rsp_state <= BURST;
        rsp_cnt   <= rsp_cnt + 1'b1;
      end
    end
  end

  // every downstream word, writes harmlessly included
  always_ff @(posedge clk) begin
    if (rsp_fire) rd_buf <= m_rsp_rdata;
  end

  // count never runs past the last beat of the current command
  a_cnt_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_cnt <= last_idx);

endmodule

// File: design/icb_unalign_bridge.sv
// ========================================
// ICB unaligned access bridge
// ========================================
module icb_unalign_bridge import unalign_pkg::*; #(
  parameter int ADDR_W     = 32,
  parameter int LEN_W      = 3,
  parameter int OUTS_DEPTH = 16
) (
  input  logic              clk,
  input  logic              rst_n,
  // upstream command
  input  logic              sa_cmd_valid,
  output logic              sa_cmd_ready,
  input  logic [ADDR_W-1:0] sa_cmd_addr,
  input  logic              sa_cmd_read,
  input  logic [LEN_W-1:0]  sa_cmd_len,
  // upstream write data
  input  logic              sa_w_valid,
  output logic              sa_w_ready,
  input  logic [DATA_W-1:0] sa_wdata,
  input  logic [STRB_W-1:0] sa_wmask,
  // upstream response
  output logic              sa_rsp_valid,
  input  logic              sa_rsp_ready,
  output logic [DATA_W-1:0] sa_rsp_rdata,
  output logic              sa_rsp_err,
  // downstream command
  output logic              m_cmd_valid,
  input  logic              m_cmd_ready,
  output logic [ADDR_W-1:0] m_cmd_addr,
  output logic              m_cmd_read,
  output logic [DATA_W-1:0] m_cmd_wdata,
  output logic [STRB_W-1:0] m_cmd_wmask,
  // downstream response
  input  logic              m_rsp_valid,
  output logic              m_rsp_ready,
  input  logic [DATA_W-1:0] m_rsp_rdata,
  input  logic              m_rsp_err
);

  // queue head
  logic              cmd_full;
  logic              fifo_valid;
  logic [ADDR_W-1:0] fifo_addr;
  logic              fifo_read;
  logic [LEN_W-1:0]  fifo_len;
  logic              pop;
  // current command, shared by both realigners
  logic              cur_read;
  logic [OFFS_W-1:0] cur_offset;
  logic [LEN_W-1:0]  cur_len;
  logic              beat_fire;
  logic              last_beat;
  beat_state_t       issue_state;
  logic              buf_valid;
  logic              rsp_done;
  logic              rsp_idle;

  assign sa_cmd_ready = !cmd_full;

  icb_cmd_fifo #(
    .ADDR_W     (ADDR_W),
    .LEN_W      (LEN_W),
    .OUTS_DEPTH (OUTS_DEPTH)
  ) u_cmd_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (sa_cmd_valid && sa_cmd_ready),
    .push_addr (sa_cmd_addr),
    .push_read (sa_cmd_read),
    .push_len  (sa_cmd_len),
    .pop       (pop),
    .full      (cmd_full),
    .pop_valid (fifo_valid),
    .pop_addr  (fifo_addr),
    .pop_read  (fifo_read),
    .pop_len   (fifo_len)
  );

  icb_beat_issuer #(
    .ADDR_W (ADDR_W),
    .LEN_W  (LEN_W)
  ) u_issuer (
    .clk         (clk),
    .rst_n       (rst_n),
    .fifo_valid  (fifo_valid),
    .fifo_addr   (fifo_addr),
    .fifo_read   (fifo_read),
    .fifo_len    (fifo_len),
    .m_cmd_ready (m_cmd_ready),
    .sa_w_valid  (sa_w_valid),
    .buf_valid   (buf_valid),
    .rsp_done    (rsp_done),
    .rsp_idle    (rsp_idle),
    .pop         (pop),
    .m_cmd_valid (m_cmd_valid),
    .m_cmd_addr  (m_cmd_addr),
    .m_cmd_read  (m_cmd_read),
    .sa_w_ready  (sa_w_ready),
    .cur_read    (cur_read),
    .cur_offset  (cur_offset),
    .cur_len     (cur_len),
    .beat_fire   (beat_fire),
    .last_beat   (last_beat),
    .issue_state (issue_state)
  );

  icb_wdata_realign u_wdata_realign (
    .clk         (clk),
    .rst_n       (rst_n),
    .sa_wdata    (sa_wdata),
    .sa_wmask    (sa_wmask),
    .cur_offset  (cur_offset),
    .issue_state (issue_state),
    .beat_fire   (beat_fire),
    .last_beat   (last_beat),
    .cur_read    (cur_read),
    .m_wdata     (m_cmd_wdata),
    .m_wmask     (m_cmd_wmask),
    .buf_valid   (buf_valid)
  );

  icb_rsp_realign #(
    .LEN_W (LEN_W)
  ) u_rsp_realign (
    .clk          (clk),
    .rst_n        (rst_n),
    .m_rsp_valid  (m_rsp_valid),
    .m_rsp_rdata  (m_rsp_rdata),
    .m_rsp_err    (m_rsp_err),
    .sa_rsp_ready (sa_rsp_ready),
    .cur_read     (cur_read),
    .cur_offset   (cur_offset),
    .cur_len      (cur_len),
    .m_rsp_ready  (m_rsp_ready),
    .sa_rsp_valid (sa_rsp_valid),
    .sa_rsp_rdata (sa_rsp_rdata),
    .sa_rsp_err   (sa_rsp_err),
    .rsp_done     (rsp_done),
    .rsp_idle     (rsp_idle)
  );

endmodule

// File: dv/icb_mem_model.sv
// ========================================
// downstream word memory model
// ========================================
module icb_mem_model #(
  parameter int ADDR_W = 32,
  parameter int WORDS  = 256
) (
  input  logic              clk,
  input  logic              rst_n,
  // holds cmd_ready low
  input  logic              stall,
  // flag err on responses to this word
  input  logic              err_on,
  input  logic [ADDR_W-1:0] err_addr,
  input  logic              cmd_valid,
  output logic              cmd_ready,
  input  logic [ADDR_W-1:0] cmd_addr,
  input  logic              cmd_read,
  input  logic [31:0]       cmd_wdata,
  input  logic [3:0]        cmd_wmask,
  output logic              rsp_valid,
  input  logic              rsp_ready,
  output logic [31:0]       rsp_rdata,
  output logic              rsp_err
);

  localparam int IDX_W = $clog2(WORDS);

  logic [31:0] mem [WORDS];
  // pending responses as {err, rdata}
  logic [32:0] rsp_q [$];
  int          gap;

  initial begin
    cmd_ready = 1'b0;
    rsp_valid = 1'b0;
    rsp_rdata = '0;
    rsp_err   = 1'b0;
    gap       = 0;
    // fill mixes every index bit
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = (32'(i) * 32'h9e3779b1) ^ 32'h3c5aa5c3;
    end
  end

  always @(posedge clk) begin : mem_proc
    logic [IDX_W-1:0] idx;
    logic             done;
    idx  = cmd_addr[IDX_W+1:2];
    done = rsp_valid && rsp_ready;
    if (!rst_n) begin
      cmd_ready <= 1'b0;
      rsp_valid <= 1'b0;
      rsp_q.delete();
    end else begin
      if (cmd_valid && cmd_ready) begin
        // byte-masked write, read returns the stored word
        for (int b = 0; b < 4; b++) begin
          if (!cmd_read && cmd_wmask[b]) mem[idx][8*b +: 8] = cmd_wdata[8*b +: 8];
        end
        rsp_q.push_back({err_on && (cmd_addr == err_addr), cmd_read ? mem[idx] : 32'h0});
      end
      // 0 to 3 idle cycles ahead of each response
      if (!rsp_valid || done) begin
        if (rsp_q.size() > 0 && gap == 0) begin
          {rsp_err, rsp_rdata} <= rsp_q.pop_front();
          rsp_valid <= 1'b1;
          gap       <= $urandom_range(0, 3);
        end else begin
          rsp_valid <= 1'b0;
          if (gap > 0) gap <= gap - 1;
        end
      end
      cmd_ready <= !stall && ($urandom_range(0, 3) != 0);
    end
  end

endmodule

// File: dv/tb_icb_unalign_bridge.sv
// ========================================
// ICB unaligned bridge testbench
// ========================================
module tb_icb_unalign_bridge import unalign_pkg::*;;

  localparam int ADDR_W     = 32;
  localparam int LEN_W      = 3;
  localparam int OUTS_DEPTH = 16;
  localparam int MEM_BYTES  = 1024;
  localparam int N_RAND     = 40;
  // basic, unaligned write and readback, burst reads, random, queue fill, error
  localparam int N_CMDS     = 4 + 6 + 4 + N_RAND + (OUTS_DEPTH + 1) + 3;
  localparam int MAX_CYCLES = 40 * N_CMDS + 100;

  logic              clk;
  logic              rst_n;
  logic              sa_cmd_valid;
  logic              sa_cmd_ready;
  logic [ADDR_W-1:0] sa_cmd_addr;
  logic              sa_cmd_read;
  logic [LEN_W-1:0]  sa_cmd_len;
  logic              sa_w_valid;
  logic              sa_w_ready;
  logic [DATA_W-1:0] sa_wdata;
  logic [STRB_W-1:0] sa_wmask;
  logic              sa_rsp_valid;
  logic              sa_rsp_ready;
  logic [DATA_W-1:0] sa_rsp_rdata;
  logic              sa_rsp_err;
  logic              m_cmd_valid;
  logic              m_cmd_ready;
  logic [ADDR_W-1:0] m_cmd_addr;
  logic              m_cmd_read;
  logic [DATA_W-1:0] m_cmd_wdata;
  logic [STRB_W-1:0] m_cmd_wmask;
  logic              m_rsp_valid;
  logic              m_rsp_ready;
  logic [DATA_W-1:0] m_rsp_rdata;
  logic              m_rsp_err;
  logic              stall;
  logic              err_on;
  logic [ADDR_W-1:0] err_word;

  // byte image of the memory as the upstream side sees it
  logic [7:0]  ref_mem [MEM_BYTES];
  // {read, len, addr} waiting for the command handshake
  logic [35:0] cmd_q [$];
  // {wmask, wdata} upstream write beats
  logic [35:0] w_q [$];
  // {read, addr, wmask, wdata} expected downstream beats
  logic [68:0] dcmd_q [$];
  // {read, err, rdata} expected upstream responses
  logic [33:0] exp_q [$];
  int          n_acc = 0;
  int          cycles = 0;
  int          n_cmd_err = 0;
  int          n_rsp_err = 0;
  int          n_other = 0;

  icb_unalign_bridge #(
    .ADDR_W     (ADDR_W),
    .LEN_W      (LEN_W),
    .OUTS_DEPTH (OUTS_DEPTH)
  ) dut0 (.*);

  icb_mem_model #(.ADDR_W(ADDR_W), .WORDS(MEM_BYTES / 4)) mem0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .err_on    (err_on),
    .err_addr  (err_word),
    .cmd_valid (m_cmd_valid),
    .cmd_ready (m_cmd_ready),
    .cmd_addr  (m_cmd_addr),
    .cmd_read  (m_cmd_read),
    .cmd_wdata (m_cmd_wdata),
    .cmd_wmask (m_cmd_wmask),
    .rsp_valid (m_rsp_valid),
    .rsp_ready (m_rsp_ready),
    .rsp_rdata (m_rsp_rdata),
    .rsp_err   (m_rsp_err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ========================================
  // reference model
  // ========================================
  // initial memory contents, same fill as the memory model
  function automatic logic [7:0] fill_byte(input int a);
    logic [31:0] w;
    w = (32'(a / 4) * 32'h9e3779b1) ^ 32'h3c5aa5c3;
    return w[8*(a % 4) +: 8];
  endfunction

  // downstream beats, one extra when the start is unaligned
  function automatic int ref_beats(input logic [31:0] addr, input int len);
    return len + 1 + ((addr[1:0] != 2'b00) ? 1 : 0);
  endfunction

  // read beat k is the four bytes at addr+4k upwards
  function automatic logic [31:0] ref_rword(input logic [31:0] addr, input int k);
    int a;
    a = addr + 4 * k;
    return {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
  endfunction

  // err comes with the downstream word whose response is forwarded
  function automatic logic ref_err(input logic [31:0] addr, input logic rd, input int len,
                                   input int k);
    logic [31:0] word;
    word = {addr[31:2], 2'b00} +
           4 * (rd ? k + (addr[1:0] != 2'b00) : ref_beats(addr, len) - 1);
    return err_on && (word == err_word);
  endfunction

  // one bit per data bit of each enabled byte
  function automatic logic [31:0] mask_bits(input logic [3:0] m);
    logic [31:0] r;
    for (int b = 0; b < 4; b++) r[8*b +: 8] = {8{m[b]}};
    return r;
  endfunction

  // queue one command with its beats and expected results
  task automatic send_cmd(input logic [31:0] addr, input logic rd, input int len);
    logic [31:0]  wd;
    logic [3:0]   wm;
    // written bytes and mask bits laid out from the base word
    logic [287:0] lane_d;
    logic [35:0]  lane_m;
    int           o;
    lane_d = '0;
    lane_m = '0;
    o = addr[1:0];
    cmd_q.push_back({rd, LEN_W'(len), addr});
    for (int k = 0; k <= len; k++) begin
      if (rd) begin
        exp_q.push_back({1'b1, ref_err(addr, rd, len, k), ref_rword(addr, k)});
      end else begin
        wd = $urandom;
        wm = $urandom_range(0, 15);
        w_q.push_back({wm, wd});
        for (int b = 0; b < 4; b++) begin
          lane_m[o + 4 * k + b] = wm[b];
          if (wm[b]) begin
            ref_mem[addr + 4 * k + b] = wd[8*b +: 8];
            lane_d[8*(o + 4 * k + b) +: 8] = wd[8*b +: 8];
          end
        end
      end
    end
    for (int j = 0; j < ref_beats(addr, len); j++) begin
      dcmd_q.push_back({rd, {addr[31:2], 2'b00} + 32'(4 * j),
                        lane_m[4*j +: 4], lane_d[32*j +: 32]});
    end
    // a write answers once
    if (!rd) exp_q.push_back({1'b0, ref_err(addr, rd, len, 0), 32'h0});
  endtask

  task automatic wait_idle();
    while (cmd_q.size() + w_q.size() + dcmd_q.size() + exp_q.size() > 0) @(posedge clk);
  endtask

  // ========================================
  // upstream drivers
  // ========================================
  always @(posedge clk) begin
    if (rst_n) begin
      if (sa_cmd_valid && sa_cmd_ready) begin
        void'(cmd_q.pop_front());
        n_acc <= n_acc + 1;
      end
      if (sa_w_valid && sa_w_ready) void'(w_q.pop_front());
      sa_cmd_valid <= (cmd_q.size() > 0);
      if (cmd_q.size() > 0) {sa_cmd_read, sa_cmd_len, sa_cmd_addr} <= cmd_q[0];
      sa_w_valid <= (w_q.size() > 0);
      if (w_q.size() > 0) {sa_wmask, sa_wdata} <= w_q[0];
      // random upstream back-pressure
      sa_rsp_ready <= ($urandom_range(0, 3) != 0);
    end
  end

  // ========================================
  // checker
  // ========================================
  always @(posedge clk) begin : check_proc
    logic [68:0] exp_c;
    logic [33:0] exp_r;
    if (rst_n && m_cmd_valid && m_cmd_ready) begin
      assert (dcmd_q.size() > 0) else begin
        n_other++;
        $display("downstream command at %0t when none was expected", $time);
      end
      if (dcmd_q.size() > 0) begin
        exp_c = dcmd_q.pop_front();
        assert (m_cmd_addr == exp_c[67:36]) else begin
          n_cmd_err++;
          $display("error %0t m_cmd_addr expected %h got %h", $time, exp_c[67:36], m_cmd_addr);
        end
        assert (m_cmd_read == exp_c[68]) else begin
          n_cmd_err++;
          $display("error %0t m_cmd_read expected %b got %b", $time, exp_c[68], m_cmd_read);
        end
        // write beats carry the shifted bytes and mask
        assert (exp_c[68] || m_cmd_wmask == exp_c[35:32]) else begin
          n_cmd_err++;
          $display("error %0t m_cmd_wmask expected %h got %h", $time, exp_c[35:32],
                   m_cmd_wmask);
        end
        assert (exp_c[68] || (m_cmd_wdata & mask_bits(exp_c[35:32])) == exp_c[31:0]) else begin
          n_cmd_err++;
          $display("error %0t m_cmd_wdata expected %h got %h", $time, exp_c[31:0],
                   m_cmd_wdata);
        end
      end
    end
    if (rst_n && sa_rsp_valid && sa_rsp_ready) begin
      assert (exp_q.size() > 0) else begin
        n_other++;
        $display("upstream response at %0t when none was expected", $time);
      end
      if (exp_q.size() > 0) begin
        exp_r = exp_q.pop_front();
        assert (sa_rsp_err == exp_r[32]) else begin
          n_rsp_err++;
          $display("error %0t sa_rsp_err expected %b got %b", $time, exp_r[32], sa_rsp_err);
        end
        // write responses carry no data
        assert (!exp_r[33] || sa_rsp_rdata == exp_r[31:0]) else begin
          n_rsp_err++;
          $display("error %0t sa_rsp_rdata expected %h got %h", $time, exp_r[31:0],
                   sa_rsp_rdata);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, commands did not complete", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ========================================
  // test sequence
  // ========================================
  initial begin
    int acc_mark;
    void'($urandom(32'h0deac767));
    rst_n        = 1'b0;
    sa_cmd_valid = 1'b0;
    sa_cmd_addr  = '0;
    sa_cmd_read  = 1'b0;
    sa_cmd_len   = '0;
    sa_w_valid   = 1'b0;
    sa_wdata     = '0;
    sa_wmask     = '0;
    sa_rsp_ready = 1'b0;
    stall        = 1'b0;
    err_on       = 1'b0;
    err_word     = '0;
    for (int a = 0; a < MEM_BYTES; a++) ref_mem[a] = fill_byte(a);
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    // aligned single beat and burst, then read back
    send_cmd(32'h040, 1'b0, 0);
    send_cmd(32'h080, 1'b0, 3);
    send_cmd(32'h040, 1'b1, 0);
    send_cmd(32'h080, 1'b1, 3);
    wait_idle();
    // offsets 1 to 3, read back over the full span
    for (int o = 1; o < 4; o++) send_cmd(32'h200 + 64 * o + o, 1'b0, $urandom_range(0, 7));
    for (int o = 1; o < 4; o++) send_cmd(32'h200 + 64 * o + o, 1'b1, 7);
    // unaligned burst reads
    for (int i = 0; i < 4; i++) send_cmd(32'h300 + 40 * i + (i % 3) + 1, 1'b1, 4 + i);
    wait_idle();
    // random mix
    for (int i = 0; i < N_RAND; i++) begin
      send_cmd($urandom_range(0, MEM_BYTES - 64), $urandom_range(0, 1), $urandom_range(0, 7));
    end
    wait_idle();
    // downstream stalled, queue depth plus the one in the issuer
    stall <= 1'b1;
    repeat (2) @(posedge clk);
    acc_mark = n_acc;
    for (int i = 0; i <= OUTS_DEPTH; i++) send_cmd(32'h100 + 8 * i + (i % 4), 1'b1, i % 4);
    while (n_acc < acc_mark + OUTS_DEPTH + 1) @(posedge clk);
    assert (!sa_cmd_ready) else begin
      n_other++;
      $display("command queue still ready with %0d commands held", OUTS_DEPTH + 1);
    end
    stall <= 1'b0;
    wait_idle();
    // error on the word at 0x100
    err_on   <= 1'b1;
    err_word <= 32'h100;
    @(posedge clk);
    send_cmd(32'h0f8, 1'b1, 3);
    send_cmd(32'h0f6, 1'b1, 2);
    send_cmd(32'h0f5, 1'b0, 2);
    wait_idle();
    repeat (10) @(posedge clk);
    $display("errors: command %0d, response %0d, other %0d", n_cmd_err, n_rsp_err, n_other);
    if (n_cmd_err + n_rsp_err + n_other == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
design/unalign_pkg.sv
design/icb_cmd_fifo.sv
design/icb_beat_issuer.sv
design/icb_wdata_realign.sv
design/icb_rsp_realign.sv
design/icb_unalign_bridge.sv
dv/icb_mem_model.sv
dv/tb_icb_unalign_bridge.sv

// File: Bender.yml
package:
  name: icb_unalign_bridge

sources:
  # bridge RTL, package first
  - files:
      - design/unalign_pkg.sv
      - design/icb_cmd_fifo.sv
      - design/icb_beat_issuer.sv
      - design/icb_wdata_realign.sv
      - design/icb_rsp_realign.sv
      - design/icb_unalign_bridge.sv

  # testbench and memory model
  - target: test
    files:
      - dv/icb_mem_model.sv
      - dv/tb_icb_unalign_bridge.sv
